// File: rtl/id_pkg.sv
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31; // Return address register.

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03, FN_SLLV = 6'h04,
        FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR   = 6'h08, FN_JALR = 6'h09,
        FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
        FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    // Selected by the rt field when the opcode is REGIMM.
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimm_e;

    typedef enum logic [7:0] {
        ALU_NOP = 8'h00,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
        ALU_ANDI, ALU_ORI, ALU_XORI, ALU_LUI, ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU,
        ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_SB, ALU_SH, ALU_SW,
        ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ, ALU_BGEZ, ALU_BLTZ, ALU_BGEZAL, ALU_BLTZAL,
        ALU_J, ALU_JAL, ALU_JR, ALU_JALR
    } aluop_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_EQ   = 4'd1,
        BR_NE   = 4'd2,
        BR_GTZ  = 4'd3,
        BR_LEZ  = 4'd4,
        BR_GEZ  = 4'd5,
        BR_LTZ  = 4'd6,
        BR_J    = 4'd7,
        BR_JR   = 4'd8
    } branch_kind_e;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } fwd_t;

    typedef struct packed {
        aluop_e                aluop;
        logic                  reg_we;
        logic [REG_ADDR_W-1:0] wr_addr;
        logic                  mem_to_reg;
        logic                  ram_we;
        logic                  rs_re;
        logic                  rt_re;
        branch_kind_e          branch;
        logic                  link;    // Writes the return address to LINK_REG.
    } id_ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs_data;
        logic [XLEN-1:0]       rt_data;
        logic [15:0]           imm16;
        logic [XLEN-1:0]       return_addr;
        aluop_e                aluop;
        logic                  reg_we;
        logic [REG_ADDR_W-1:0] wr_addr;
        logic                  mem_to_reg;
        logic                  ram_we;
    } ex_bundle_t;

endpackage

// File: rtl/instr_decoder.sv
module instr_decoder (
    input  logic [id_pkg::XLEN-1:0] instr_i,
    output id_pkg::id_ctrl_t        ctrl_o
);

    id_pkg::opcode_e                op;
    id_pkg::funct_e                 funct;
    id_pkg::regimm_e                rimm;
    logic [id_pkg::REG_ADDR_W-1:0]  rt;
    logic [id_pkg::REG_ADDR_W-1:0]  rd;

    assign op    = id_pkg::opcode_e'(instr_i[31:26]);
    assign funct = id_pkg::funct_e'(instr_i[5:0]);
    assign rimm  = id_pkg::regimm_e'(instr_i[20:16]);
    assign rt    = instr_i[20:16];
    assign rd    = instr_i[15:11];

    always_comb begin
        ctrl_o = '0; // Anything not decoded stays a NOP.
        case (op)
            id_pkg::OP_SPECIAL: begin
                ctrl_o.reg_we  = 1'b1;
                ctrl_o.wr_addr = rd;
                ctrl_o.rs_re   = 1'b1;
                ctrl_o.rt_re   = 1'b1;
                case (funct)
                    id_pkg::FN_AND:  ctrl_o.aluop = id_pkg::ALU_AND;
                    id_pkg::FN_OR:   ctrl_o.aluop = id_pkg::ALU_OR;
                    id_pkg::FN_XOR:  ctrl_o.aluop = id_pkg::ALU_XOR;
                    id_pkg::FN_NOR:  ctrl_o.aluop = id_pkg::ALU_NOR;
                    id_pkg::FN_ADD:  ctrl_o.aluop = id_pkg::ALU_ADD;
                    id_pkg::FN_ADDU: ctrl_o.aluop = id_pkg::ALU_ADDU;
                    id_pkg::FN_SUB:  ctrl_o.aluop = id_pkg::ALU_SUB;
                    id_pkg::FN_SUBU: ctrl_o.aluop = id_pkg::ALU_SUBU;
                    id_pkg::FN_SLT:  ctrl_o.aluop = id_pkg::ALU_SLT;
                    id_pkg::FN_SLTU: ctrl_o.aluop = id_pkg::ALU_SLTU;
                    id_pkg::FN_SLLV: ctrl_o.aluop = id_pkg::ALU_SLLV;
                    id_pkg::FN_SRLV: ctrl_o.aluop = id_pkg::ALU_SRLV;
                    id_pkg::FN_SRAV: ctrl_o.aluop = id_pkg::ALU_SRAV;
                    id_pkg::FN_SLL: begin
                        ctrl_o.aluop = id_pkg::ALU_SLL;
                        ctrl_o.rs_re = 1'b0; // The shift amount comes from shamt.
                    end
                    id_pkg::FN_SRL: begin
                        ctrl_o.aluop = id_pkg::ALU_SRL;
                        ctrl_o.rs_re = 1'b0;
                    end
                    id_pkg::FN_SRA: begin
                        ctrl_o.aluop = id_pkg::ALU_SRA;
                        ctrl_o.rs_re = 1'b0;
                    end
                    id_pkg::FN_JR: begin
                        ctrl_o.aluop  = id_pkg::ALU_JR;
                        ctrl_o.reg_we = 1'b0;
                        ctrl_o.rt_re  = 1'b0;
                        ctrl_o.branch = id_pkg::BR_JR;
                    end
                    id_pkg::FN_JALR: begin
                        ctrl_o.aluop  = id_pkg::ALU_JALR;
                        ctrl_o.rt_re  = 1'b0;
                        ctrl_o.branch = id_pkg::BR_JR;
                    end
                    default: ctrl_o = '0;
                endcase
            end
            id_pkg::OP_REGIMM: begin
                ctrl_o.rs_re = 1'b1;
                case (rimm)
                    id_pkg::RI_BLTZ: begin
                        ctrl_o.aluop  = id_pkg::ALU_BLTZ;
                        ctrl_o.branch = id_pkg::BR_LTZ;
                    end
                    id_pkg::RI_BGEZ: begin
                        ctrl_o.aluop  = id_pkg::ALU_BGEZ;
                        ctrl_o.branch = id_pkg::BR_GEZ;
                    end
                    id_pkg::RI_BLTZAL: begin
                        ctrl_o.aluop  = id_pkg::ALU_BLTZAL;
                        ctrl_o.branch = id_pkg::BR_LTZ;
                        ctrl_o.link   = 1'b1;
                    end
                    id_pkg::RI_BGEZAL: begin
                        ctrl_o.aluop  = id_pkg::ALU_BGEZAL;
                        ctrl_o.branch = id_pkg::BR_GEZ;
                        ctrl_o.link   = 1'b1;
                    end
                    default: ctrl_o = '0;
                endcase
            end
            id_pkg::OP_J: begin
                ctrl_o.aluop  = id_pkg::ALU_J;
                ctrl_o.branch = id_pkg::BR_J;
            end
            id_pkg::OP_JAL: begin
                ctrl_o.aluop  = id_pkg::ALU_JAL;
                ctrl_o.branch = id_pkg::BR_J;
                ctrl_o.link   = 1'b1;
            end
            id_pkg::OP_BEQ, id_pkg::OP_BNE: begin
                ctrl_o.rs_re  = 1'b1;
                ctrl_o.rt_re  = 1'b1;
                ctrl_o.aluop  = (op == id_pkg::OP_BEQ) ? id_pkg::ALU_BEQ : id_pkg::ALU_BNE;
                ctrl_o.branch = (op == id_pkg::OP_BEQ) ? id_pkg::BR_EQ : id_pkg::BR_NE;
            end
            id_pkg::OP_BGTZ, id_pkg::OP_BLEZ: begin
                ctrl_o.rs_re  = 1'b1;
                ctrl_o.aluop  = (op == id_pkg::OP_BGTZ) ? id_pkg::ALU_BGTZ : id_pkg::ALU_BLEZ;
                ctrl_o.branch = (op == id_pkg::OP_BGTZ) ? id_pkg::BR_GTZ : id_pkg::BR_LEZ;
            end
            id_pkg::OP_ADDI, id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU,
            id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI, id_pkg::OP_LUI: begin
                ctrl_o.reg_we  = 1'b1;
                ctrl_o.wr_addr = rt;
                ctrl_o.rs_re   = 1'b1;
                case (op)
                    id_pkg::OP_ADDI:  ctrl_o.aluop = id_pkg::ALU_ADDI;
                    id_pkg::OP_ADDIU: ctrl_o.aluop = id_pkg::ALU_ADDIU;
                    id_pkg::OP_SLTI:  ctrl_o.aluop = id_pkg::ALU_SLTI;
                    id_pkg::OP_SLTIU: ctrl_o.aluop = id_pkg::ALU_SLTIU;
                    id_pkg::OP_ANDI:  ctrl_o.aluop = id_pkg::ALU_ANDI;
                    id_pkg::OP_ORI:   ctrl_o.aluop = id_pkg::ALU_ORI;
                    id_pkg::OP_XORI:  ctrl_o.aluop = id_pkg::ALU_XORI;
                    default:          ctrl_o.aluop = id_pkg::ALU_LUI;
                endcase
            end
            id_pkg::OP_LB, id_pkg::OP_LBU, id_pkg::OP_LH, id_pkg::OP_LHU, id_pkg::OP_LW: begin
                ctrl_o.reg_we     = 1'b1;
                ctrl_o.wr_addr    = rt;
                ctrl_o.mem_to_reg = 1'b1;
                ctrl_o.rs_re      = 1'b1; // Base address only.
                case (op)
                    id_pkg::OP_LB:  ctrl_o.aluop = id_pkg::ALU_LB;
                    id_pkg::OP_LBU: ctrl_o.aluop = id_pkg::ALU_LBU;
                    id_pkg::OP_LH:  ctrl_o.aluop = id_pkg::ALU_LH;
                    id_pkg::OP_LHU: ctrl_o.aluop = id_pkg::ALU_LHU;
                    default:        ctrl_o.aluop = id_pkg::ALU_LW;
                endcase
            end
            id_pkg::OP_SB, id_pkg::OP_SH, id_pkg::OP_SW: begin
                ctrl_o.ram_we = 1'b1;
                ctrl_o.rs_re  = 1'b1;
                ctrl_o.rt_re  = 1'b1;
                case (op)
                    id_pkg::OP_SB: ctrl_o.aluop = id_pkg::ALU_SB;
                    id_pkg::OP_SH: ctrl_o.aluop = id_pkg::ALU_SH;
                    default:       ctrl_o.aluop = id_pkg::ALU_SW;
                endcase
            end
            default: ctrl_o = '0;
        endcase

        // Linking branches and JAL always write the return address.
        if (ctrl_o.link) begin
            ctrl_o.reg_we  = 1'b1;
            ctrl_o.wr_addr = id_pkg::LINK_REG;
        end
    end

endmodule

// File: rtl/operand_bypass.sv
module operand_bypass (
    input  logic [id_pkg::REG_ADDR_W-1:0] addr_i,
    input  logic                          read_en_i,
    input  logic [id_pkg::XLEN-1:0]       regfile_data_i,
    input  id_pkg::fwd_t                  ex_fwd_i,
    input  id_pkg::fwd_t                  mem_fwd_i,
    output logic [id_pkg::XLEN-1:0]       data_o
);

    logic ex_hit;
    logic mem_hit;

    // Register 0 is compared like any other address.
    assign ex_hit  = ex_fwd_i.we && (ex_fwd_i.addr == addr_i);
    assign mem_hit = mem_fwd_i.we && (mem_fwd_i.addr == addr_i);

    always_comb begin
        if (!read_en_i) begin
            data_o = '0;
        end else if (ex_hit) begin
            data_o = ex_fwd_i.data; // Youngest result wins.
        end else if (mem_hit) begin
            data_o = mem_fwd_i.data;
        end else begin
            data_o = regfile_data_i;
        end
    end

endmodule

// File: rtl/branch_resolver.sv
module branch_resolver (
    input  logic [id_pkg::XLEN-1:0] pc_i,
    input  logic [id_pkg::XLEN-1:0] instr_i,
    input  id_pkg::id_ctrl_t        ctrl_i,
    input  logic [id_pkg::XLEN-1:0] rs_data_i,
    input  logic [id_pkg::XLEN-1:0] rt_data_i,
    output logic                    taken_o,
    output logic [id_pkg::XLEN-1:0] target_o,
    output logic [id_pkg::XLEN-1:0] return_addr_o
);

    logic [id_pkg::XLEN-1:0] pc_plus4;
    logic [id_pkg::XLEN-1:0] pc_plus8;
    logic [id_pkg::XLEN-1:0] br_offset;
    logic                    rs_neg;
    logic                    rs_zero;

    assign pc_plus4  = pc_i + 32'd4;
    assign pc_plus8  = pc_i + 32'd8;
    assign br_offset = {{14{instr_i[15]}}, instr_i[15:0], 2'b00};
    assign rs_neg    = rs_data_i[id_pkg::XLEN-1];
    assign rs_zero   = (rs_data_i == '0);

    always_comb begin
        case (ctrl_i.branch)
            id_pkg::BR_EQ:  taken_o = (rs_data_i == rt_data_i);
            id_pkg::BR_NE:  taken_o = (rs_data_i != rt_data_i);
            id_pkg::BR_GTZ: taken_o = !rs_neg && !rs_zero;
            id_pkg::BR_LEZ: taken_o = rs_neg || rs_zero;
            id_pkg::BR_GEZ: taken_o = !rs_neg;
            id_pkg::BR_LTZ: taken_o = rs_neg;
            id_pkg::BR_J,
            id_pkg::BR_JR:  taken_o = 1'b1;
            default:        taken_o = 1'b0;
        endcase
    end

    // The target reads zero while nothing is taken.
    always_comb begin
        if (!taken_o) begin
            target_o = '0;
        end else if (ctrl_i.branch == id_pkg::BR_J) begin
            target_o = {pc_plus4[31:28], instr_i[25:0], 2'b00};
        end else if (ctrl_i.branch == id_pkg::BR_JR) begin
            target_o = rs_data_i;
        end else begin
            target_o = pc_plus4 + br_offset;
        end
    end

    assign return_addr_o = (ctrl_i.link || ctrl_i.aluop == id_pkg::ALU_JALR) ? pc_plus8 : '0;

endmodule

// File: rtl/load_use_interlock.sv
module load_use_interlock (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [id_pkg::XLEN-1:0]       instr_i,
    input  id_pkg::id_ctrl_t              ctrl_i,
    input  logic                          ex_load_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] ex_wr_addr_i,
    input  id_pkg::ex_bundle_t            next_i,
    output logic                          stall_o,
    output id_pkg::ex_bundle_t            ex_o
);

    logic rs_hit;
    logic rt_hit;

    // Only operands that are actually read can create a hazard.
    assign rs_hit  = ctrl_i.rs_re && (ex_wr_addr_i == instr_i[25:21]);
    assign rt_hit  = ctrl_i.rt_re && (ex_wr_addr_i == instr_i[20:16]);
    assign stall_o = ex_load_i && (rs_hit || rt_hit);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_o <= '0;
        end else if (stall_o) begin
            ex_o <= '0; // Bubble while the load result is not yet available.
        end else begin
            ex_o <= next_i;
        end
    end

endmodule

// File: rtl/id_stage.sv
module id_stage (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [id_pkg::XLEN-1:0]       pc_i,
    input  logic [id_pkg::XLEN-1:0]       instr_i,
    input  logic [id_pkg::XLEN-1:0]       rs_data_i,
    input  logic [id_pkg::XLEN-1:0]       rt_data_i,
    input  id_pkg::fwd_t                  ex_fwd_i,
    input  id_pkg::fwd_t                  mem_fwd_i,
    input  logic                          ex_load_i,
    input  logic [id_pkg::REG_ADDR_W-1:0] ex_wr_addr_i,
    output logic                          stall_o,
    output logic                          branch_taken_o,
    output logic [id_pkg::XLEN-1:0]       branch_target_o,
    output id_pkg::ex_bundle_t            ex_o
);

    id_pkg::id_ctrl_t        ctrl;
    id_pkg::ex_bundle_t      next_bundle;
    logic [id_pkg::XLEN-1:0] rs_val;
    logic [id_pkg::XLEN-1:0] rt_val;
    logic [id_pkg::XLEN-1:0] return_addr;

    instr_decoder u_decoder (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    operand_bypass u_rs_bypass (
        .addr_i         (instr_i[25:21]),
        .read_en_i      (ctrl.rs_re),
        .regfile_data_i (rs_data_i),
        .ex_fwd_i       (ex_fwd_i),
        .mem_fwd_i      (mem_fwd_i),
        .data_o         (rs_val)
    );

    operand_bypass u_rt_bypass (
        .addr_i         (instr_i[20:16]),
        .read_en_i      (ctrl.rt_re),
        .regfile_data_i (rt_data_i),
        .ex_fwd_i       (ex_fwd_i),
        .mem_fwd_i      (mem_fwd_i),
        .data_o         (rt_val)
    );

    branch_resolver u_branch (
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .ctrl_i        (ctrl),
        .rs_data_i     (rs_val),
        .rt_data_i     (rt_val),
        .taken_o       (branch_taken_o),
        .target_o      (branch_target_o),
        .return_addr_o (return_addr)
    );

    assign next_bundle.pc          = pc_i;
    assign next_bundle.rs_data     = rs_val;
    assign next_bundle.rt_data     = rt_val;
    assign next_bundle.imm16       = instr_i[15:0];
    assign next_bundle.return_addr = return_addr;
    assign next_bundle.aluop       = ctrl.aluop;
    assign next_bundle.reg_we      = ctrl.reg_we;
    assign next_bundle.wr_addr     = ctrl.wr_addr;
    assign next_bundle.mem_to_reg  = ctrl.mem_to_reg;
    assign next_bundle.ram_we      = ctrl.ram_we;

    load_use_interlock u_interlock (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr_i),
        .ctrl_i       (ctrl),
        .ex_load_i    (ex_load_i),
        .ex_wr_addr_i (ex_wr_addr_i),
        .next_i       (next_bundle),
        .stall_o      (stall_o),
        .ex_o         (ex_o)
    );

endmodule

// File: tests/id_model.svh
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// Kept instructions in aluop_e order, so entry i decodes to aluop i+1.
// Bits [13:8] hold the opcode and bits [5:0] the funct or REGIMM rt code.
// The last entry is an opcode that the stage does not decode.
localparam logic [15:0] KEPT_CODES [45] = '{
    16'h0024, 16'h0025, 16'h0026, 16'h0027, 16'h0020, 16'h0021, 16'h0022, 16'h0023,
    16'h002a, 16'h002b, 16'h0000, 16'h0002, 16'h0003, 16'h0004, 16'h0006, 16'h0007,
    16'h0c00, 16'h0d00, 16'h0e00, 16'h0f00, 16'h0800, 16'h0900, 16'h0a00, 16'h0b00,
    16'h2000, 16'h2400, 16'h2100, 16'h2500, 16'h2300, 16'h2800, 16'h2900, 16'h2b00,
    16'h0400, 16'h0500, 16'h0700, 16'h0600, 16'h0101, 16'h0100, 16'h0111, 16'h0110,
    16'h0200, 16'h0300, 16'h0008, 16'h0009, 16'h3f00
};

function automatic id_pkg::aluop_e decode_aluop(input logic [31:0] instr);
    logic [15:0]    code;
    logic           hit;
    id_pkg::aluop_e op;
    op = id_pkg::ALU_NOP;
    for (int i = 0; i < 44; i++) begin
        code = KEPT_CODES[6'(i)];
        hit  = (instr[31:26] == code[13:8]);
        if (code[13:8] == id_pkg::OP_SPECIAL) hit = hit && (instr[5:0] == code[5:0]);
        if (code[13:8] == id_pkg::OP_REGIMM) hit = hit && (instr[20:16] == code[4:0]);
        if (hit) op = id_pkg::aluop_e'(8'(i + 1));
    end
    return op;
endfunction

// Shifts by shamt and plain jumps leave rs alone.
function automatic logic reads_rs(input id_pkg::aluop_e a);
    return !(a inside {id_pkg::ALU_NOP, id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA,
                       id_pkg::ALU_J, id_pkg::ALU_JAL});
endfunction

function automatic logic reads_rt(input id_pkg::aluop_e a);
    return (a >= id_pkg::ALU_AND && a <= id_pkg::ALU_SRAV)
        || (a >= id_pkg::ALU_SB && a <= id_pkg::ALU_BNE); // Stores, BEQ and BNE.
endfunction

function automatic logic [31:0] forward_operand(
    input logic [4:0]   addr,
    input logic         re,
    input logic [31:0]  rf,
    input id_pkg::fwd_t exf,
    input id_pkg::fwd_t memf
);
    if (!re) return '0;
    if (exf.we && exf.addr == addr) return exf.data;
    if (memf.we && memf.addr == addr) return memf.data;
    return rf;
endfunction

function automatic id_pkg::ex_bundle_t expected_bundle(
    input logic [31:0] pc,
    input logic [31:0] instr,
    input logic [31:0] rs_val,
    input logic [31:0] rt_val
);
    id_pkg::ex_bundle_t b;
    id_pkg::aluop_e     a;
    logic               link;
    a    = decode_aluop(instr);
    link = a inside {id_pkg::ALU_JAL, id_pkg::ALU_BGEZAL, id_pkg::ALU_BLTZAL};
    b             = '0;
    b.pc          = pc;
    b.rs_data     = rs_val;
    b.rt_data     = rt_val;
    b.imm16       = instr[15:0];
    b.aluop       = a;
    b.return_addr = (link || a == id_pkg::ALU_JALR) ? pc + 32'd8 : 32'd0;
    b.ram_we      = a inside {id_pkg::ALU_SB, id_pkg::ALU_SH, id_pkg::ALU_SW};
    if (link) begin
        b.reg_we  = 1'b1;
        b.wr_addr = id_pkg::LINK_REG;
    end else if (a != id_pkg::ALU_NOP && instr[31:26] == id_pkg::OP_SPECIAL) begin
        b.reg_we  = (a != id_pkg::ALU_JR); // JR keeps rd as address but writes nothing.
        b.wr_addr = instr[15:11];
    end else if (a >= id_pkg::ALU_ANDI && a <= id_pkg::ALU_LW) begin
        b.reg_we     = 1'b1;
        b.wr_addr    = instr[20:16];
        b.mem_to_reg = (a >= id_pkg::ALU_LB);
    end
    return b;
endfunction

function automatic logic cond_holds(
    input id_pkg::aluop_e a,
    input logic [31:0]    rs,
    input logic [31:0]    rt
);
    case (a)
        id_pkg::ALU_BEQ:  return rs == rt;
        id_pkg::ALU_BNE:  return rs != rt;
        id_pkg::ALU_BGTZ: return $signed(rs) > 0;
        id_pkg::ALU_BLEZ: return $signed(rs) <= 0;
        id_pkg::ALU_BGEZ, id_pkg::ALU_BGEZAL: return $signed(rs) >= 0;
        id_pkg::ALU_BLTZ, id_pkg::ALU_BLTZAL: return $signed(rs) < 0;
        id_pkg::ALU_J, id_pkg::ALU_JAL, id_pkg::ALU_JR, id_pkg::ALU_JALR: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [31:0] jump_target(
    input id_pkg::aluop_e a,
    input logic [31:0]    pc,
    input logic [31:0]    instr,
    input logic [31:0]    rs
);
    logic [31:0] pc4;
    pc4 = pc + 32'd4;
    if (a == id_pkg::ALU_J || a == id_pkg::ALU_JAL) return {pc4[31:28], instr[25:0], 2'b00};
    if (a == id_pkg::ALU_JR || a == id_pkg::ALU_JALR) return rs;
    return pc4 + (32'($signed(instr[15:0])) << 2);
endfunction

function automatic logic [15:0] ctrl_fields(input id_pkg::ex_bundle_t b);
    return {b.aluop, b.reg_we, b.wr_addr, b.mem_to_reg, b.ram_we};
endfunction

`endif

// File: tests/tb_id_stage.sv
module tb_id_stage;

    `include "id_model.svh"

    localparam int N_CYCLES = 2000;
    localparam int TIMEOUT  = N_CYCLES + N_CYCLES / 10;

    logic               clk_i;
    logic               rst_n_i;
    logic [31:0]        pc_i;
    logic [31:0]        instr_i;
    logic [31:0]        rs_data_i;
    logic [31:0]        rt_data_i;
    id_pkg::fwd_t       ex_fwd_i;
    id_pkg::fwd_t       mem_fwd_i;
    logic               ex_load_i;
    logic [4:0]         ex_wr_addr_i;
    logic               stall_o;
    logic               branch_taken_o;
    logic [31:0]        branch_target_o;
    id_pkg::ex_bundle_t ex_o;

    logic [31:0]        lfsr;
    int                 cycle_cnt;
    int                 ex_errs;
    int                 stall_errs;
    int                 branch_errs;

    id_pkg::aluop_e     exp_op;
    logic [31:0]        exp_rs;
    logic [31:0]        exp_rt;
    logic [31:0]        exp_target;
    logic               exp_stall;
    logic               exp_taken;
    id_pkg::ex_bundle_t exp_cap;  // What the ID/EX register should take at the next edge.
    id_pkg::ex_bundle_t prev_cap;
    logic               prev_rst;

    id_stage dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Mostly registers 0 to 3, so that forwarding and load-use hits are common.
    function automatic logic [4:0] pick_reg();
        if (rand_bits(2) != 0) begin
            return 5'(rand_bits(2));
        end else begin
            return 5'(rand_bits(5));
        end
    endfunction

    task automatic apply_stimulus();
        logic [5:0]  idx;
        logic [15:0] code;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] low;
        if (!stall_o) begin // A stalled instruction stays in ID.
            idx  = 6'(rand_bits(6) % 45);
            code = KEPT_CODES[idx];
            rs   = pick_reg();
            rt   = (code[13:8] == id_pkg::OP_REGIMM) ? code[4:0] : pick_reg();
            low  = 16'(rand_bits(16));
            if (code[13:8] == id_pkg::OP_SPECIAL) low[5:0] = code[5:0];
            instr_i = {code[13:8], rs, rt, low};
            pc_i    = rand_bits(30) << 2;
        end
        rs_data_i = (rand_bits(3) == 0) ? 32'd0 : rand_bits(32);
        rt_data_i = (rand_bits(2) == 0) ? rs_data_i : rand_bits(32);
        ex_fwd_i.we    = 1'(rand_bits(1));
        ex_fwd_i.addr  = pick_reg();
        ex_fwd_i.data  = rand_bits(32);
        mem_fwd_i.we   = 1'(rand_bits(1));
        mem_fwd_i.addr = pick_reg();
        mem_fwd_i.data = rand_bits(32);
        ex_load_i      = (rand_bits(2) == 0);
        ex_wr_addr_i   = pick_reg();
    endtask

    always_comb begin
        exp_op     = decode_aluop(instr_i);
        exp_rs     = forward_operand(instr_i[25:21], reads_rs(exp_op), rs_data_i,
                                     ex_fwd_i, mem_fwd_i);
        exp_rt     = forward_operand(instr_i[20:16], reads_rt(exp_op), rt_data_i,
                                     ex_fwd_i, mem_fwd_i);
        exp_stall  = ex_load_i && ((reads_rs(exp_op) && ex_wr_addr_i == instr_i[25:21])
                                || (reads_rt(exp_op) && ex_wr_addr_i == instr_i[20:16]));
        exp_taken  = cond_holds(exp_op, exp_rs, exp_rt);
        exp_target = jump_target(exp_op, pc_i, instr_i, exp_rs);
        if (exp_stall) begin
            exp_cap = '0;
        end else begin
            exp_cap = expected_bundle(pc_i, instr_i, exp_rs, exp_rt);
        end
    end

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_rst  <= 1'b0;
            prev_cap  <= '0;
            cycle_cnt <= 0;
        end else begin
            prev_rst  <= 1'b1;
            prev_cap  <= exp_cap;
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    a_first_edge: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !prev_rst |-> ex_o == '0)
        else begin
            ex_errs++;
            $display("mismatch ex_o after reset: expected 0 got %h", $sampled(ex_o));
        end

    a_ex_ctrl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_rst |-> ctrl_fields(ex_o) == ctrl_fields(prev_cap))
        else begin
            ex_errs++;
            $display("mismatch ex_o ctrl: expected %h got %h",
                     ctrl_fields($sampled(prev_cap)), ctrl_fields($sampled(ex_o)));
        end

    a_ex_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_rst |-> ex_o.pc == prev_cap.pc)
        else begin
            ex_errs++;
            $display("mismatch ex_o.pc: expected %h got %h",
                     $sampled(prev_cap.pc), $sampled(ex_o.pc));
        end

    a_ex_imm: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_rst |-> ex_o.imm16 == prev_cap.imm16)
        else begin
            ex_errs++;
            $display("mismatch ex_o.imm16: expected %h got %h",
                     $sampled(prev_cap.imm16), $sampled(ex_o.imm16));
        end

    a_ex_rs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_rst |-> ex_o.rs_data == prev_cap.rs_data)
        else begin
            ex_errs++;
            $display("mismatch ex_o.rs_data: expected %h got %h",
                     $sampled(prev_cap.rs_data), $sampled(ex_o.rs_data));
        end

    a_ex_rt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_rst |-> ex_o.rt_data == prev_cap.rt_data)
        else begin
            ex_errs++;
            $display("mismatch ex_o.rt_data: expected %h got %h",
                     $sampled(prev_cap.rt_data), $sampled(ex_o.rt_data));
        end

    a_ex_link: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_rst |-> ex_o.return_addr == prev_cap.return_addr)
        else begin
            ex_errs++;
            $display("mismatch ex_o.return_addr: expected %h got %h",
                     $sampled(prev_cap.return_addr), $sampled(ex_o.return_addr));
        end

    a_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_o == exp_stall)
        else begin
            stall_errs++;
            $display("mismatch stall_o: expected %h got %h", exp_stall, stall_o);
        end

    a_taken: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !exp_stall |-> branch_taken_o == exp_taken)
        else begin
            branch_errs++;
            $display("mismatch branch_taken_o: expected %h got %h", exp_taken, branch_taken_o);
        end

    a_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !exp_stall && exp_taken |-> branch_target_o == exp_target)
        else begin
            branch_errs++;
            $display("mismatch branch_target_o: expected %h got %h",
                     exp_target, branch_target_o);
        end

    initial begin
        wait (cycle_cnt >= TIMEOUT);
        $display("timeout: the run did not end within %0d cycles", TIMEOUT);
        $display("Verification failed");
        $finish;
    end

    initial begin
        lfsr         = 32'h59cd;
        ex_errs      = 0;
        stall_errs   = 0;
        branch_errs  = 0;
        rst_n_i      = 1'b0;
        pc_i         = '0;
        instr_i      = '0;
        rs_data_i    = '0;
        rt_data_i    = '0;
        ex_fwd_i     = '0;
        mem_fwd_i    = '0;
        ex_load_i    = 1'b0;
        ex_wr_addr_i = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        assert (ex_o == '0) else begin
            ex_errs++;
            $display("mismatch ex_o in reset: expected 0 got %h", ex_o);
        end
        rst_n_i = 1'b1;
        repeat (N_CYCLES) begin
            apply_stimulus();
            @(negedge clk_i);
        end
        @(negedge clk_i); // The last instruction still has to reach ex_o.
        $display("errors: ex_o %0d, stall %0d, branch %0d", ex_errs, stall_errs, branch_errs);
        if (ex_errs + stall_errs + branch_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+tests
rtl/id_pkg.sv
rtl/instr_decoder.sv
rtl/operand_bypass.sv
rtl/branch_resolver.sv
rtl/load_use_interlock.sv
rtl/id_stage.sv
tests/tb_id_stage.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_id_stage and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_id_stage -f flist.f -o sim_id
	./obj_dir/sim_id > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
